// ==== src/wb_cfg.svh ====
////////////////////
// fixed RV32 sizes for the back end of the pipeline
// the widths are not meant to change, and nothing here is a module parameter
// WB_IDX_W must stay equal to clog2 of WB_NUM_REGS
////////////////////

`ifndef WB_CFG_SVH
`define WB_CFG_SVH

// data path width
`define WB_XLEN 32

// integer register file
`define WB_NUM_REGS 32
`define WB_IDX_W 5

`endif

// ==== src/wb_pkg.sv ====
////////////////////
// types shared by memory stage 2, writeback, register file and forwarder
// alu_result doubles as the load address, so its low bits are the byte offset
// rd_src code 2'b11 is never legal
////////////////////

`include "wb_cfg.svh"

package wb_pkg;

    typedef logic [`WB_XLEN-1:0] word_t;
    typedef logic [`WB_IDX_W-1:0] reg_idx_t;

    typedef enum logic [1:0] {
        RD_SRC_ALU = 2'd0,
        RD_SRC_CSR = 2'd1,
        RD_SRC_MEM = 2'd2
    } rd_src_e;

    typedef enum logic [1:0] {
        LS_BYTE = 2'd0,
        LS_HALF = 2'd1,
        LS_WORD = 2'd2
    } load_size_e;

    // one memory word seen whole, as bytes or as halfwords
    typedef union packed {
        word_t              word;
        logic [3:0][7:0]    bytes;
        logic [1:0][15:0]   halves;
    } mem_word_u;

    typedef struct packed {
        reg_idx_t   rd_idx;
        logic       rd_we;
        rd_src_e    rd_src;
        word_t      alu_result;
        word_t      csr_old_val;
        load_size_e load_size;
        logic       load_unsigned;
        logic       sim_exit_req;
    } m1_to_m2_s;

    typedef struct packed {
        reg_idx_t   rd_idx;
        logic       rd_we;
        rd_src_e    rd_src;
        word_t      alu_result;
        word_t      csr_old_val;
        word_t      mem_rdata;
        logic       sim_exit_req;
    } m2_to_w_s;

    // register file write port
    typedef struct packed {
        logic       we;
        reg_idx_t   idx;
        word_t      val;
    } rf_write_s;

    // one in-flight producer as the forwarder sees it
    typedef struct packed {
        logic       produces_rd;
        logic       val_avail;
        reg_idx_t   idx;
        word_t      val;
    } fwd_src_s;

    // destination value of an item, picked by rd_src
    function automatic word_t rd_value(m2_to_w_s item);
        unique case (item.rd_src)
            RD_SRC_ALU: return item.alu_result;
            RD_SRC_CSR: return item.csr_old_val;
            RD_SRC_MEM: return item.mem_rdata;
            default:    return 32'hdead_beef;
        endcase
    endfunction

endpackage

// ==== src/load_align.sv ====
////////////////////
// memory stage 2: holds the item and the raw read word for one cycle
// the raw word must arrive in the same cycle as m1_valid
// misaligned loads are not trapped; the assertion flags them instead
////////////////////

module load_align import wb_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        m1_valid,
    input  m1_to_m2_s   m1,
    input  word_t       mem_rdata,
    output logic        m2_valid,
    output m2_to_w_s    m2,
    output fwd_src_s    m2_fwd
);

    logic        valid_q;
    m1_to_m2_s   item_q;
    mem_word_u   raw_q;

    logic [1:0]  offset;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic        is_load;
    word_t       aligned;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= m1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            item_q <= m1;
            raw_q  <= mem_rdata;
        end
    end

    assign offset  = item_q.alu_result[1:0];
    assign ld_byte = raw_q.bytes[offset];
    assign ld_half = raw_q.halves[offset[1]];
    assign is_load = (item_q.rd_src == RD_SRC_MEM);

    // extend by zero for lbu/lhu, by the top bit otherwise
    always_comb begin
        unique case (item_q.load_size)
            LS_BYTE: aligned = {{24{ld_byte[7] & ~item_q.load_unsigned}}, ld_byte};
            LS_HALF: aligned = {{16{ld_half[15] & ~item_q.load_unsigned}}, ld_half};
            default: aligned = raw_q.word;
        endcase
    end

    always_comb begin
        m2.rd_idx       = item_q.rd_idx;
        m2.rd_we        = item_q.rd_we;
        m2.rd_src       = item_q.rd_src;
        m2.alu_result   = item_q.alu_result;
        m2.csr_old_val  = item_q.csr_old_val;
        m2.mem_rdata    = aligned;
        m2.sim_exit_req = item_q.sim_exit_req;
    end

    assign m2_valid = valid_q;

    // load data is ready here already, so the value is always available
    assign m2_fwd.produces_rd = valid_q && item_q.rd_we;
    assign m2_fwd.val_avail   = 1'b1;
    assign m2_fwd.idx         = item_q.rd_idx;
    assign m2_fwd.val         = rd_value(m2);

    // upstream must never hand over a misaligned load
    a_load_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        valid_q && is_load |->
            !(item_q.load_size == LS_HALF && offset[0]) &&
            !(item_q.load_size == LS_WORD && offset != 2'b00));

endmodule

// ==== src/writeback_stage.sv ====
////////////////////
// writeback: last pipeline register and the register file write port
// always ready as there is no write-miss path
// flush and stall gate the strobe in the current cycle only
// the forwarding view ignores flush
////////////////////

module writeback_stage import wb_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        flush,
    input  logic        m2_valid,
    input  m2_to_w_s    m2,
    output rf_write_s   rf_wr,
    output fwd_src_s    w_fwd,
    output logic        exit_req
);

    logic      valid_q;
    m2_to_w_s  item_q;

    word_t     rd_val;
    logic      commit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= m2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            item_q <= m2;
        end
    end

    // destination value by source
    assign rd_val = rd_value(item_q);

    // item retires this cycle
    assign commit = valid_q && !flush && !stall;

    always_comb begin
        rf_wr.we  = commit && item_q.rd_we;
        rf_wr.idx = item_q.rd_idx;
        rf_wr.val = rd_val;
    end

    // only flush drops the exit request of a held item
    assign exit_req = valid_q && item_q.sim_exit_req && !flush;

    always_comb begin
        w_fwd.produces_rd = valid_q && item_q.rd_we;
        w_fwd.val_avail   = 1'b1;
        w_fwd.idx         = item_q.rd_idx;
        w_fwd.val         = rd_val;
    end

    // the 4th rd_src code must never reach writeback
    a_rd_src_legal: assert property (@(posedge clk) disable iff (!rst_n)
        valid_q |-> item_q.rd_src inside {RD_SRC_ALU, RD_SRC_CSR, RD_SRC_MEM});

endmodule

// ==== src/reg_file.sv ====
////////////////////
// integer register file, one write port, two read ports
// reads are combinational, so a write shows up after the edge
// x0 is never written and reads zero
////////////////////

`include "wb_cfg.svh"

module reg_file import wb_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  rf_write_s   rf_wr,
    input  reg_idx_t    rs1_idx,
    input  reg_idx_t    rs2_idx,
    output word_t       rf_rs1,
    output word_t       rf_rs2
);

    word_t regs [`WB_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `WB_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_wr.we && rf_wr.idx != '0) begin
            regs[rf_wr.idx] <= rf_wr.val;
        end
    end

    // entry 0 stays at its reset value
    assign rf_rs1 = regs[rs1_idx];
    assign rf_rs2 = regs[rs2_idx];

    a_wr_idx_known: assert property (@(posedge clk) disable iff (!rst_n)
        rf_wr.we |-> !$isunknown(rf_wr.idx));

endmodule

// ==== src/operand_forwarder.sv ====
////////////////////
// bypass for the two decode read ports, purely combinational
// youngest producer wins: memory stage 2, then writeback, then the register file
// val_avail is carried for a later stall path but does not change the choice
////////////////////

module operand_forwarder import wb_pkg::*; (
    input  reg_idx_t    rs1_idx,
    input  reg_idx_t    rs2_idx,
    input  fwd_src_s    m2_fwd,
    input  fwd_src_s    w_fwd,
    input  word_t       rf_rs1,
    input  word_t       rf_rs2,
    output word_t       rs1_val,
    output word_t       rs2_val
);

    // one read port against both producers
    function automatic word_t pick(
        reg_idx_t idx,
        fwd_src_s m2_src,
        fwd_src_s w_src,
        word_t    rf_val
    );
        logic m2_hit;
        logic w_hit;

        m2_hit = m2_src.produces_rd && (m2_src.idx == idx);
        w_hit  = w_src.produces_rd && (w_src.idx == idx);

        if (idx == '0) begin
            return '0;
        end else if (m2_hit) begin
            return m2_src.val;
        end else if (w_hit) begin
            return w_src.val;
        end
        return rf_val;
    endfunction

    // x0 writes can still be in flight, hence the index check first
    always_comb begin
        rs1_val = pick(rs1_idx, m2_fwd, w_fwd, rf_rs1);
        rs2_val = pick(rs2_idx, m2_fwd, w_fwd, rf_rs2);
    end

endmodule

// ==== src/wb_subsystem_top.sv ====
////////////////////
// back end of the five-stage pipeline, memory stage 2 onward
// m1 item and data memory word arrive together with m1_valid
// stall holds every stage; flush only masks the writeback strobe and exit
// an issued item is written two edges after it is sampled
////////////////////

module wb_subsystem_top import wb_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        flush,
    input  logic        m1_valid,
    input  m1_to_m2_s   m1,
    input  word_t       mem_rdata,
    input  reg_idx_t    rs1_idx,
    input  reg_idx_t    rs2_idx,
    output word_t       rs1_val,
    output word_t       rs2_val,
    output rf_write_s   rf_wr,
    output logic        exit_req
);

    logic       m2_valid;
    m2_to_w_s   m2;
    fwd_src_s   m2_fwd;
    fwd_src_s   w_fwd;
    word_t      rf_rs1;
    word_t      rf_rs2;

    load_align load_align_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .m1_valid  (m1_valid),
        .m1        (m1),
        .mem_rdata (mem_rdata),
        .m2_valid  (m2_valid),
        .m2        (m2),
        .m2_fwd    (m2_fwd)
    );

    writeback_stage writeback_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .flush     (flush),
        .m2_valid  (m2_valid),
        .m2        (m2),
        .rf_wr     (rf_wr),
        .w_fwd     (w_fwd),
        .exit_req  (exit_req)
    );

    reg_file reg_file_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rf_wr     (rf_wr),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .rf_rs1    (rf_rs1),
        .rf_rs2    (rf_rs2)
    );

    operand_forwarder operand_forwarder_inst (
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .m2_fwd    (m2_fwd),
        .w_fwd     (w_fwd),
        .rf_rs1    (rf_rs1),
        .rf_rs2    (rf_rs2),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val)
    );

endmodule

// ==== verif/wb_subsystem_tb.sv ====
////////////////////
// testbench for the pipeline back end, memory stage 2 onward
// vectors come from verif/wb_stimulus.txt, opened relative to the project root
// one vector per clock cycle, outputs checked at the falling edge
// the run stops at a cycle limit set from the vector count
////////////////////

module wb_subsystem_tb import wb_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 10;
    localparam int FIELD_COUNT  = 17;

    // one line of the stimulus file
    typedef struct packed {
        logic [39:0] cmd;
        m1_to_m2_s   m1;
        word_t       mem;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        word_t       exp_rs1;
        word_t       exp_rs2;
        rf_write_s   exp_wr;
        logic        exp_exit;
    } vector_t;

    logic       clk;
    logic       rst_n;
    logic       stall;
    logic       flush;
    logic       m1_valid;
    m1_to_m2_s  m1;
    word_t      mem_rdata;
    reg_idx_t   rs1_idx;
    reg_idx_t   rs2_idx;
    word_t      rs1_val;
    word_t      rs2_val;
    rf_write_s  rf_wr;
    logic       exit_req;

    vector_t    vectors[$];
    int         seed = 76;
    int         pass_count = 0;
    int         fail_count = 0;
    int         cycle_count = 0;
    int         cycle_limit = 0;
    logic       vector_ok;

    wb_subsystem_top wb_subsystem_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .flush     (flush),
        .m1_valid  (m1_valid),
        .m1        (m1),
        .mem_rdata (mem_rdata),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .rf_wr     (rf_wr),
        .exit_req  (exit_req)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input word_t actual,
                              input word_t expected, input int vec_num);
        if (actual !== expected) begin
            $display("ERROR vector %0d %s: got %h, expected %h",
                     vec_num, name, actual, expected);
            vector_ok = 1'b0;
        end
    endtask

    // idx and val only matter when a write is expected
    task automatic check_write(input rf_write_s actual, input rf_write_s expected,
                               input int vec_num);
        if (expected.we && actual !== expected) begin
            $display("ERROR vector %0d rf_wr: got %h, expected %h",
                     vec_num, actual, expected);
            vector_ok = 1'b0;
        end else if (!expected.we && actual.we !== 1'b0) begin
            $display("ERROR vector %0d rf_wr.we: got %h, expected %h",
                     vec_num, actual.we, expected.we);
            vector_ok = 1'b0;
        end
    endtask

    task automatic check_flag(input string name, input logic actual,
                              input logic expected, input int vec_num);
        if (actual !== expected) begin
            $display("ERROR vector %0d %s: got %h, expected %h",
                     vec_num, name, actual, expected);
            vector_ok = 1'b0;
        end
    endtask

    task automatic load_vectors(output bit ok);
        int               fd;
        int               n;
        bit               done;
        logic [39:0]      cmd_txt;
        logic [8*256-1:0] skip_buf;
        logic [31:0]      f [FIELD_COUNT];
        vector_t          v;

        ok   = 1'b1;
        done = 1'b0;
        fd   = $fopen("verif/wb_stimulus.txt", "r");
        if (fd == 0) begin
            $display("the stimulus file verif/wb_stimulus.txt could not be opened");
            ok = 1'b0;
            return;
        end
        while (!done) begin
            n = $fscanf(fd, "%s", cmd_txt);
            if (n != 1) begin
                done = 1'b1;
            end else if (cmd_txt == 40'("#")) begin
                n = $fgets(skip_buf, fd);
            end else begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                            f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
                if (n != FIELD_COUNT) begin
                    $display("stimulus vector %0d has missing fields", vectors.size());
                    ok   = 1'b0;
                    done = 1'b1;
                end else begin
                    v.cmd              = cmd_txt;
                    v.m1.rd_idx        = f[0][4:0];
                    v.m1.rd_we         = f[1][0];
                    v.m1.rd_src        = rd_src_e'(f[2][1:0]);
                    v.m1.alu_result    = f[3];
                    v.m1.csr_old_val   = f[4];
                    v.m1.load_size     = load_size_e'(f[5][1:0]);
                    v.m1.load_unsigned = f[6][0];
                    v.m1.sim_exit_req  = f[7][0];
                    v.mem              = f[8];
                    v.rs1              = f[9][4:0];
                    v.rs2              = f[10][4:0];
                    v.exp_rs1          = f[11];
                    v.exp_rs2          = f[12];
                    v.exp_wr.we        = f[13][0];
                    v.exp_wr.idx       = f[14][4:0];
                    v.exp_wr.val       = f[15];
                    v.exp_exit         = f[16][0];
                    vectors.push_back(v);
                end
            end
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("the stimulus file holds no vectors");
            ok = 1'b0;
        end
    endtask

    // drive one vector on the rising edge, check it at the falling edge
    task automatic run_vector(input int idx);
        vector_t     v;
        m1_to_m2_s   filler;
        word_t       fill_word;
        logic [95:0] rnd;
        logic        is_issue;
        logic        known;

        v         = vectors[idx];
        vector_ok = 1'b1;
        rnd       = {$random(seed), $random(seed), $random(seed)};
        filler    = rnd[$bits(m1_to_m2_s)-1:0];
        fill_word = $random(seed);
        is_issue  = (v.cmd == 40'("issue"));
        known     = is_issue || v.cmd == 40'("idle") || v.cmd == 40'("stall")
                    || v.cmd == 40'("flush");

        @(posedge clk);
        stall    <= (v.cmd == 40'("stall"));
        flush    <= (v.cmd == 40'("flush"));
        m1_valid <= is_issue;
        // idle fields are don't-care while valid is low
        m1        <= is_issue ? v.m1 : filler;
        mem_rdata <= is_issue ? v.mem : fill_word;
        rs1_idx  <= v.rs1;
        rs2_idx  <= v.rs2;

        @(negedge clk);
        if (!known) begin
            $display("vector %0d has an unknown command", idx);
            vector_ok = 1'b0;
        end
        check_word("rs1_val", rs1_val, v.exp_rs1, idx);
        check_word("rs2_val", rs2_val, v.exp_rs2, idx);
        check_write(rf_wr, v.exp_wr, idx);
        check_flag("exit_req", exit_req, v.exp_exit, idx);

        if (vector_ok) begin
            pass_count++;
            $display("vector %0d %0s: pass", idx, v.cmd);
        end else begin
            fail_count++;
            $display("vector %0d %0s: fail", idx, v.cmd);
        end
    endtask

    initial begin
        bit load_ok;

        rst_n     = 1'b0;
        stall     = 1'b0;
        flush     = 1'b0;
        m1_valid  = 1'b0;
        m1        = '0;
        mem_rdata = '0;
        rs1_idx   = '0;
        rs2_idx   = '0;

        load_vectors(load_ok);
        cycle_limit = RESET_CYCLES + 4 * vectors.size() + 50;
        if (!load_ok) begin
            fail_count++;
            $display("stimulus load: fail");
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        if (load_ok) begin
            foreach (vectors[i]) begin
                run_vector(i);
            end
        end

        @(posedge clk);
        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+src
src/wb_pkg.sv
src/load_align.sv
src/writeback_stage.sv
src/reg_file.sv
src/operand_forwarder.sv
src/wb_subsystem_top.sv
verif/wb_subsystem_tb.sv

// ==== Makefile ====
# Verilator build and run for the writeback back end
VERILATOR ?= verilator
TOP       ?= wb_subsystem_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) src/wb_cfg.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/wb_stimulus.txt ====
# cmd rd we src alu csr size uns exit mem_rdata rs1 rs2 | exp rs1 rs2 we idx val exit
# all hex; src 0 alu 1 csr 2 mem; size 0 byte 1 half 2 word; one line per cycle
issue 01 1 0 11111111 00000000 0 0 0 00000000 01 02 00000000 00000000 0 00 00000000 0
issue 02 1 1 00000040 22222222 0 0 0 00000000 01 02 11111111 00000000 0 00 00000000 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 01 02 11111111 22222222 1 01 11111111 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 01 02 11111111 22222222 1 02 22222222 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 01 02 11111111 22222222 0 00 00000000 0
issue 03 1 2 00001000 00000000 0 0 0 80f17f2e 01 02 11111111 22222222 0 00 00000000 0
issue 04 1 2 00001001 00000000 0 0 0 80f17f2e 03 01 0000002e 11111111 0 00 00000000 0
issue 05 1 2 00001002 00000000 0 0 0 80f17f2e 04 03 0000007f 0000002e 1 03 0000002e 0
issue 06 1 2 00001003 00000000 0 0 0 80f17f2e 05 04 fffffff1 0000007f 1 04 0000007f 0
issue 07 1 2 00001002 00000000 0 1 0 80f17f2e 06 05 ffffff80 fffffff1 1 05 fffffff1 0
issue 08 1 2 00001003 00000000 0 1 0 80f17f2e 07 06 000000f1 ffffff80 1 06 ffffff80 0
issue 09 1 2 00001000 00000000 1 0 0 80f17f2e 08 07 00000080 000000f1 1 07 000000f1 0
issue 0a 1 2 00001002 00000000 1 0 0 80f17f2e 09 08 00007f2e 00000080 1 08 00000080 0
issue 0b 1 2 00001002 00000000 1 1 0 80f17f2e 0a 09 ffff80f1 00007f2e 1 09 00007f2e 0
issue 0c 1 2 00001000 00000000 1 1 0 80f17f2e 0b 0a 000080f1 ffff80f1 1 0a ffff80f1 0
issue 0d 1 2 00001000 00000000 2 0 0 80f17f2e 0c 0b 00007f2e 000080f1 1 0b 000080f1 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 0d 0c 80f17f2e 00007f2e 1 0c 00007f2e 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 0d 03 80f17f2e 0000002e 1 0d 80f17f2e 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 05 0d fffffff1 80f17f2e 0 00 00000000 0
issue 14 1 0 aaaa0001 00000000 0 0 0 00000000 14 00 00000000 00000000 0 00 00000000 0
issue 14 1 0 aaaa0002 00000000 0 0 0 00000000 14 00 aaaa0001 00000000 0 00 00000000 0
issue 14 1 1 00000300 aaaa0003 0 0 0 00000000 14 00 aaaa0002 00000000 1 14 aaaa0001 0
issue 00 1 0 deadbeef 00000000 0 0 0 00000000 14 00 aaaa0003 00000000 1 14 aaaa0002 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 14 00 aaaa0003 00000000 1 14 aaaa0003 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 14 00 aaaa0003 00000000 1 00 deadbeef 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 14 00 aaaa0003 00000000 0 00 00000000 0
issue 14 0 0 bbbbbbbb 00000000 0 0 0 00000000 14 00 aaaa0003 00000000 0 00 00000000 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 14 00 aaaa0003 00000000 0 00 00000000 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 14 00 aaaa0003 00000000 0 00 00000000 0
issue 15 1 0 cccc0001 00000000 0 0 0 00000000 15 14 00000000 aaaa0003 0 00 00000000 0
issue 15 1 0 cccc0002 00000000 0 0 1 00000000 15 14 cccc0001 aaaa0003 0 00 00000000 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 15 14 cccc0002 aaaa0003 1 15 cccc0001 0
flush 00 0 0 00000000 00000000 0 0 0 00000000 15 14 cccc0002 aaaa0003 0 00 00000000 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 15 14 cccc0001 aaaa0003 0 00 00000000 0
issue 16 1 0 dddd0016 00000000 0 0 0 00000000 16 17 00000000 00000000 0 00 00000000 0
issue 17 1 0 dddd0017 00000000 0 0 0 00000000 16 17 dddd0016 00000000 0 00 00000000 0
issue 18 1 0 dddd0018 00000000 0 0 0 00000000 16 17 dddd0016 dddd0017 1 16 dddd0016 0
stall 00 0 0 00000000 00000000 0 0 0 00000000 17 18 dddd0017 dddd0018 0 00 00000000 0
stall 00 0 0 00000000 00000000 0 0 0 00000000 17 16 dddd0017 dddd0016 0 00 00000000 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 17 18 dddd0017 dddd0018 1 17 dddd0017 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 17 18 dddd0017 dddd0018 1 18 dddd0018 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 17 18 dddd0017 dddd0018 0 00 00000000 0
issue 19 1 0 eeee0019 00000000 0 0 1 00000000 19 00 00000000 00000000 0 00 00000000 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 19 00 eeee0019 00000000 0 00 00000000 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 19 00 eeee0019 00000000 1 19 eeee0019 1
idle  00 0 0 00000000 00000000 0 0 0 00000000 19 00 eeee0019 00000000 0 00 00000000 0
issue 1a 1 2 00002000 00000000 1 0 0 c3d2e1f0 1a 1b 00000000 00000000 0 00 00000000 0
issue 1b 1 2 00002000 00000000 1 1 0 c3d2e1f0 1a 1b ffffe1f0 00000000 0 00 00000000 0
issue 1c 1 2 00002001 00000000 0 0 0 c3d2e1f0 1a 1b ffffe1f0 0000e1f0 1 1a ffffe1f0 0
issue 1d 1 2 00002004 00000000 2 0 0 01020304 1c 1b ffffffe1 0000e1f0 1 1b 0000e1f0 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 1d 1c 01020304 ffffffe1 1 1c ffffffe1 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 1d 1a 01020304 ffffe1f0 1 1d 01020304 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 1d 03 01020304 0000002e 0 00 00000000 0
idle  00 0 0 00000000 00000000 0 0 0 00000000 01 02 11111111 22222222 0 00 00000000 0
